/* Bender.yml */
package:
  name: core16

sources:
  - logic/core_isa_pkg.sv
  - logic/core_pipe_pkg.sv
  - logic/core_fetch.sv
  - logic/core_regfile.sv
  - logic/core_decode.sv
  - logic/core_execute.sv
  - logic/core_memory.sv
  - logic/core_top.sv
  - target: test
    files:
      - tests/core_top_tb.sv

/* logic/core_decode.sv */
/*
 * Field split and immediate forming. Register indices are driven from the
 * decode register, so operands are read during the execute cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module core_decode
    import core_isa_pkg::*, core_pipe_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic       i_stall,
    input  wire fetch_reg_t i_fetch,
    output reg_idx_t        o_rd_idx1,
    output reg_idx_t        o_rd_idx2,
    output decode_reg_t     o_decode
);

    inst_rrr_t   rrr;
    inst_rri_t   rri;
    inst_ri_t    ri;
    word_t       simm_ext;
    decode_reg_t dec_next;

    assign rrr = i_fetch.inst;
    assign rri = i_fetch.inst;
    assign ri  = i_fetch.inst;

    assign simm_ext = {{9{rri.simm[6]}}, rri.simm};

    always_comb begin
        dec_next       = '0;
        dec_next.valid = i_fetch.valid;
        dec_next.op    = rrr.opcode;
        case (rrr.opcode)
            ADD, NAND: begin
                dec_next.tgt  = rrr.reg_a;
                dec_next.src1 = rrr.reg_b;
                dec_next.src2 = rrr.reg_c;
            end
            ADDI, LW: begin
                dec_next.tgt  = rri.reg_a;
                dec_next.src1 = rri.reg_b;
                dec_next.imm  = simm_ext;
            end
            LUI: begin
                // Upper ten bits, r0 as base
                dec_next.tgt = ri.reg_a;
                dec_next.imm = {ri.limm, 6'b0};
            end
            SW: begin
                // Store data travels as source 2
                dec_next.src1 = rri.reg_b;
                dec_next.src2 = rri.reg_a;
                dec_next.imm  = simm_ext;
            end
            default: begin
                dec_next.valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_decode.valid <= 1'b0;
        end else if (!i_stall) begin
            o_decode <= dec_next;
        end
    end

    assign o_rd_idx1 = o_decode.src1;
    assign o_rd_idx2 = o_decode.src2;

endmodule

`default_nettype wire

/* logic/core_execute.sv */
/*
 * Forwarding, load-use stall and ALU. A dependent instruction right behind
 * a load waits exactly one cycle; all other dependences forward.
 */
`timescale 1ns/100ps
`default_nettype none

module core_execute
    import core_isa_pkg::*, core_pipe_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire decode_reg_t i_decode,
    input  wire word_t       i_rd_data1,
    input  wire word_t       i_rd_data2,
    input  wire reg_write_t  i_mem_fwd,
    output logic             o_stall,
    output exec_reg_t        o_exec
);

    word_t     op1;
    word_t     op2;
    word_t     alu_b;
    alu_op_e   alu_op;
    exec_reg_t exec_next;

    // ------------------------------
    // Operand forwarding
    // ------------------------------

    // Youngest producer wins and r0 never forwards
    function automatic word_t fwd_operand(input reg_idx_t src, input word_t rf_data);
        word_t val;
        if (o_exec.valid && o_exec.tgt != reg_idx_t'(0) && o_exec.tgt == src) begin
            val = o_exec.result;
        end else if (i_mem_fwd.en && i_mem_fwd.tgt != reg_idx_t'(0)
                     && i_mem_fwd.tgt == src) begin
            val = i_mem_fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    always_comb begin
        op1 = fwd_operand(i_decode.src1, i_rd_data1);
        op2 = fwd_operand(i_decode.src2, i_rd_data2);
    end

    // Load data is not ready until the memory stage
    assign o_stall = o_exec.valid && o_exec.op == LW && o_exec.tgt != reg_idx_t'(0)
                     && (o_exec.tgt == i_decode.src1 || o_exec.tgt == i_decode.src2);

    // ------------------------------
    // ALU
    // ------------------------------

    always_comb begin
        case (i_decode.op)
            ADD: begin
                alu_op = ALU_ADD;
                alu_b  = op2;
            end
            NAND: begin
                alu_op = ALU_NAND;
                alu_b  = op2;
            end
            // Address and immediate forms
            default: begin
                alu_op = ALU_ADD;
                alu_b  = i_decode.imm;
            end
        endcase
    end

    always_comb begin
        exec_next.valid   = i_decode.valid;
        exec_next.op      = i_decode.op;
        exec_next.tgt     = i_decode.tgt;
        exec_next.result  = (alu_op == ALU_NAND) ? ~(op1 & alu_b) : op1 + alu_b;
        exec_next.st_data = op2;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || o_stall) begin
            // Bubble
            o_exec.valid <= 1'b0;
        end else begin
            o_exec <= exec_next;
        end
    end

    // The bubble resolves the hazard, so stalls come singly
    a_stall_single: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stall |=> !o_stall);

    a_bubble_invalid: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stall |=> !o_exec.valid);

endmodule

`default_nettype wire

/* logic/core_fetch.sv */
/*
 * Program counter and fetch register. Instruction memory must answer
 * combinationally for o_pc within the same cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module core_fetch
    import core_isa_pkg::*, core_pipe_pkg::*;
#(
    parameter word_t P_RESET_PC = '0
) (
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    input  wire logic  i_stall,
    input  wire word_t i_inst,
    output word_t      o_pc,
    output fetch_reg_t o_fetch
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc          <= P_RESET_PC;
            o_fetch.valid <= 1'b0;
        end else if (!i_stall) begin
            o_pc          <= o_pc + word_t'(1);
            o_fetch.valid <= 1'b1;
            o_fetch.inst  <= i_inst;
        end
    end

    // Load-use stall freezes the front end
    a_pc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_stall |=> $stable(o_pc));

endmodule

`default_nettype wire

/* logic/core_isa_pkg.sv */
/*
 * Instruction set of the 16-bit load/store core: six opcodes, eight registers.
 * Opcodes 6 and 7 are reserved and execute as no-operations.
 */
`default_nettype none

package core_isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0] reg_idx_t;
    typedef logic signed [6:0] simm_t;
    typedef logic [9:0] limm_t;

    typedef enum logic [2:0] {
        ADD  = 3'd0,
        ADDI = 3'd1,
        NAND = 3'd2,
        LUI  = 3'd3,
        SW   = 3'd4,
        LW   = 3'd5,
        RSV6 = 3'd6,
        RSV7 = 3'd7
    } opcode_e;

    typedef enum logic {
        ALU_ADD  = 1'b0,
        ALU_NAND = 1'b1
    } alu_op_e;

    // ------------------------------
    // Instruction formats
    // ------------------------------

    // ADD, NAND
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   reg_a;
        reg_idx_t   reg_b;
        logic [3:0] pad;
        reg_idx_t   reg_c;
    } inst_rrr_t;

    // ADDI, SW, LW
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t reg_a;
        reg_idx_t reg_b;
        simm_t    simm;
    } inst_rri_t;

    // LUI
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t reg_a;
        limm_t    limm;
    } inst_ri_t;

endpackage

`default_nettype wire

/* logic/core_memory.sv */
/*
 * Data memory port and memory register. The data memory must return read
 * data combinationally for o_mem_addr and write on the rising edge.
 */
`timescale 1ns/100ps
`default_nettype none

module core_memory
    import core_isa_pkg::*, core_pipe_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire exec_reg_t i_exec,
    input  wire word_t     i_mem_rd_data,
    output word_t          o_mem_addr,
    output word_t          o_mem_wr_data,
    output logic           o_mem_wr_en,
    output reg_write_t     o_fwd,
    output reg_write_t     o_wr
);

    assign o_mem_addr    = i_exec.result;
    assign o_mem_wr_data = i_exec.st_data;
    assign o_mem_wr_en   = i_exec.valid && i_exec.op == SW;

    // SW carries target zero and so writes nothing
    assign o_fwd.en   = i_exec.valid && i_exec.tgt != reg_idx_t'(0);
    assign o_fwd.tgt  = i_exec.tgt;
    assign o_fwd.data = (i_exec.op == LW) ? i_mem_rd_data : i_exec.result;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wr.en <= 1'b0;
        end else begin
            o_wr <= o_fwd;
        end
    end

endmodule

`default_nettype wire

/* logic/core_pipe_pkg.sv */
/*
 * Pipeline registers between the stages. Every struct carries its own valid
 * or enable bit, and payload fields mean nothing while that bit is low.
 */
`default_nettype none

package core_pipe_pkg;

    import core_isa_pkg::*;

    // Fetch to decode
    typedef struct packed {
        logic  valid;
        word_t inst;
    } fetch_reg_t;

    // Decode to execute, operands are read from the register file later
    typedef struct packed {
        logic     valid;
        opcode_e  op;
        reg_idx_t tgt;
        reg_idx_t src1;
        reg_idx_t src2;
        word_t    imm;
    } decode_reg_t;

    // Execute to memory
    typedef struct packed {
        logic     valid;
        opcode_e  op;
        reg_idx_t tgt;
        word_t    result;
        word_t    st_data;
    } exec_reg_t;

    // Register write, also used as a forwarding source
    typedef struct packed {
        logic     en;
        reg_idx_t tgt;
        word_t    data;
    } reg_write_t;

endpackage

`default_nettype wire

/* logic/core_regfile.sv */
/*
 * Eight registers with r0 reading zero. Reads are combinational and see a
 * write presented in the same cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module core_regfile
    import core_isa_pkg::*, core_pipe_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire reg_idx_t   i_rd_idx1,
    input  wire reg_idx_t   i_rd_idx2,
    output word_t           o_rd_data1,
    output word_t           o_rd_data2,
    input  wire reg_write_t i_wr
);

    word_t regs [1:7];

    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == reg_idx_t'(0)) begin
            val = '0;
        end else if (i_wr.en && i_wr.tgt == idx) begin
            // Write-through
            val = i_wr.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        o_rd_data1 = read_port(i_rd_idx1);
        o_rd_data2 = read_port(i_rd_idx2);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.en && i_wr.tgt != reg_idx_t'(0)) begin
            regs[i_wr.tgt] <= i_wr.data;
        end
    end

endmodule

`default_nettype wire

/* logic/core_top.sv */
/*
 * Five-stage core without control flow. Instruction and data memories sit
 * outside and answer combinationally; there is no external back-pressure.
 */
`timescale 1ns/100ps
`default_nettype none

module core_top
    import core_isa_pkg::*, core_pipe_pkg::*;
#(
    parameter word_t P_RESET_PC = '0
) (
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    input  wire word_t i_inst,
    output word_t      o_pc,
    input  wire word_t i_mem_rd_data,
    output word_t      o_mem_addr,
    output word_t      o_mem_wr_data,
    output logic       o_mem_wr_en
);

    logic        stall;
    fetch_reg_t  fetch;
    decode_reg_t decode;
    exec_reg_t   exec;
    reg_write_t  wr;
    reg_idx_t    rd_idx1;
    reg_idx_t    rd_idx2;
    word_t       rd_data1;
    word_t       rd_data2;

    core_fetch #(
        .P_RESET_PC(P_RESET_PC)
    ) i_fetch (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_stall(stall),
        .i_inst (i_inst),
        .o_pc   (o_pc),
        .o_fetch(fetch)
    );

    core_decode i_decode (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_stall  (stall),
        .i_fetch  (fetch),
        .o_rd_idx1(rd_idx1),
        .o_rd_idx2(rd_idx2),
        .o_decode (decode)
    );

    core_regfile i_regfile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rd_idx1 (rd_idx1),
        .i_rd_idx2 (rd_idx2),
        .o_rd_data1(rd_data1),
        .o_rd_data2(rd_data2),
        .i_wr      (wr)
    );

    core_execute i_execute (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_decode  (decode),
        .i_rd_data1(rd_data1),
        .i_rd_data2(rd_data2),
        .i_mem_fwd (wr),
        .o_stall   (stall),
        .o_exec    (exec)
    );

    // Memory register feeds both writeback and forwarding
    core_memory i_memory (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_exec       (exec),
        .i_mem_rd_data(i_mem_rd_data),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wr_data(o_mem_wr_data),
        .o_mem_wr_en  (o_mem_wr_en),
        .o_fwd        (),
        .o_wr         (wr)
    );

endmodule

`default_nettype wire

/* tests/core_top_tb.sv */
/*
 * Random programs checked against an instruction-level model. Data memory
 * decodes the low eight address bits, so every access lands in 256 words.
 */
`timescale 1ns/100ps
`default_nettype none

module core_top_tb
    import core_isa_pkg::*;
();

    localparam int          N_PROGS     = 8;
    localparam int          PROG_LEN    = 200;
    localparam int          N_RANDOM    = PROG_LEN - 8;
    localparam int          RST_CYCLES  = 16;
    localparam int          DRAIN       = 12;
    // Worst case stalls once per instruction
    localparam int          CYCLE_LIMIT = N_PROGS * (RST_CYCLES + 2 * PROG_LEN + 2 * DRAIN);
    localparam logic [31:0] SEED        = 32'hd9bc_1cff;
    localparam word_t       NOP         = 16'he000;

    logic  i_clk;
    logic  i_rst;
    word_t i_inst;
    word_t o_pc;
    word_t i_mem_rd_data;
    word_t o_mem_addr;
    word_t o_mem_wr_data;
    logic  o_mem_wr_en;

    word_t       imem [PROG_LEN];
    word_t       dmem [256];
    word_t       model_mem [256];
    word_t       model_regs [8];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] lfsr_state;
    int          n_exp;
    int          exp_stalls;
    int          stores_seen;
    int          holds_seen;
    int          cycle_count;
    logic        run_active;
    logic        first_cycle;
    logic        prev_hold;
    word_t       prev_pc;

    core_top #(
        .P_RESET_PC(16'h0000)
    ) i_dut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_inst       (i_inst),
        .o_pc         (o_pc),
        .i_mem_rd_data(i_mem_rd_data),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wr_data(o_mem_wr_data),
        .o_mem_wr_en  (o_mem_wr_en)
    );

    always #4 i_clk = ~i_clk;

    // ------------------------------
    // Memories
    // ------------------------------

    // Past the program end the core fetches reserved no-ops
    assign i_inst        = (o_pc < word_t'(PROG_LEN)) ? imem[o_pc] : NOP;
    assign i_mem_rd_data = dmem[o_mem_addr[7:0]];

    always @(posedge i_clk) begin
        if (o_mem_wr_en) begin
            dmem[o_mem_addr[7:0]] = o_mem_wr_data;
        end
    end

    // ------------------------------
    // Stimulus and model
    // ------------------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Three hot registers make back-to-back dependences common
    function automatic reg_idx_t pick_reg();
        reg_idx_t r;
        if (rand_bits(2) != 16'd0) begin
            r = reg_idx_t'(rand_bits(2) % 16'd3 + 16'd1);
        end else begin
            r = reg_idx_t'(rand_bits(3));
        end
        return r;
    endfunction

    function automatic word_t random_inst();
        word_t      raw;
        logic [2:0] op;
        reg_idx_t   a;
        reg_idx_t   b;
        reg_idx_t   c;
        word_t      inst;
        raw = rand_bits(16);
        op  = raw[15:13];
        if (op >= 3'd6 && rand_bits(1) == 16'd1) begin
            op = LW;
        end
        a = pick_reg();
        b = pick_reg();
        c = pick_reg();
        case (opcode_e'(op))
            ADD, NAND:    inst = {op, a, b, raw[6:3], c};
            ADDI, SW, LW: inst = {op, a, b, raw[6:0]};
            LUI:          inst = {op, a, raw[9:0]};
            default:      inst = {op, raw[12:0]};
        endcase
        return inst;
    endfunction

    // Each word depends on all eight address bits
    function automatic word_t fill_word(input int a);
        logic [7:0] lo;
        lo = a[7:0];
        return {lo ^ 8'h5a, ~lo};
    endfunction

    function automatic logic reads_reg(input word_t inst, input reg_idx_t r);
        logic hit;
        case (opcode_e'(inst[15:13]))
            ADD, NAND: hit = inst[9:7] == r || inst[2:0] == r;
            ADDI, LW:  hit = inst[9:7] == r;
            SW:        hit = inst[9:7] == r || inst[12:10] == r;
            default:   hit = 1'b0;
        endcase
        return hit;
    endfunction

    task automatic model_exec(input word_t inst);
        reg_idx_t a;
        reg_idx_t b;
        reg_idx_t c;
        word_t    addr;
        word_t    res;
        logic     wr;
        a    = inst[12:10];
        b    = inst[9:7];
        c    = inst[2:0];
        addr = model_regs[b] + {{9{inst[6]}}, inst[6:0]};
        res  = '0;
        wr   = 1'b1;
        case (opcode_e'(inst[15:13]))
            ADD:  res = model_regs[b] + model_regs[c];
            ADDI: res = addr;
            NAND: res = ~(model_regs[b] & model_regs[c]);
            LUI:  res = {inst[9:0], 6'b0};
            LW:   res = model_mem[addr[7:0]];
            SW: begin
                model_mem[addr[7:0]] = model_regs[a];
                exp_addr.push_back(addr);
                exp_data.push_back(model_regs[a]);
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && a != reg_idx_t'(0)) begin
            model_regs[a] = res;
        end
    endtask

    task automatic build_program();
        reg_idx_t lw_tgt;
        word_t    inst;
        exp_addr.delete();
        exp_data.delete();
        exp_stalls = 0;
        lw_tgt     = '0;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        for (int a = 0; a < 256; a++) begin
            model_mem[a] = fill_word(a);
            dmem[a]      = fill_word(a);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i < N_RANDOM) begin
                inst = random_inst();
            end else begin
                // Dump r0 to r7 to addresses 56 to 63
                inst = {SW, reg_idx_t'(i - N_RANDOM), 3'd0, 7'(56 + i - N_RANDOM)};
            end
            imem[i] = inst;
            if (lw_tgt != reg_idx_t'(0) && reads_reg(inst, lw_tgt)) begin
                exp_stalls++;
            end
            lw_tgt = (inst[15:13] == LW) ? inst[12:10] : reg_idx_t'(0);
            model_exec(inst);
        end
    endtask

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic report_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_store();
        assert (stores_seen < n_exp) else begin
            $display("Store to %h arrived after all expected stores", o_mem_addr);
            report_failure();
        end
        assert (o_mem_addr == exp_addr[stores_seen]) else begin
            $display("[FAIL] o_mem_addr got %h expected %h", o_mem_addr, exp_addr[stores_seen]);
            report_failure();
        end
        assert (o_mem_wr_data == exp_data[stores_seen]) else begin
            $display("[FAIL] o_mem_wr_data got %h expected %h",
                     o_mem_wr_data, exp_data[stores_seen]);
            report_failure();
        end
        stores_seen++;
    endtask

    always @(negedge i_clk) begin
        if (run_active) begin
            if (first_cycle) begin
                assert (o_pc == 16'h0000 && !o_mem_wr_en) else begin
                    $display("[FAIL] o_pc %h o_mem_wr_en %h after reset, expected 0000 and 0",
                             o_pc, o_mem_wr_en);
                    report_failure();
                end
                first_cycle = 1'b0;
            end else if (o_pc == prev_pc) begin
                assert (!prev_hold) else begin
                    $display("Program counter held for two cycles in a row at %h", o_pc);
                    report_failure();
                end
                prev_hold = 1'b1;
                holds_seen++;
            end else begin
                assert (o_pc == prev_pc + 16'h1) else begin
                    $display("[FAIL] o_pc got %h expected %h", o_pc, prev_pc + 16'h1);
                    report_failure();
                end
                prev_hold = 1'b0;
            end
            prev_pc = o_pc;
            if (o_mem_wr_en) begin
                check_store();
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d stores arrived",
                     cycle_count, stores_seen, n_exp);
            report_failure();
        end
    end

    initial begin
        i_clk       = 1'b0;
        i_rst       = 1'b1;
        lfsr_state  = SEED;
        run_active  = 1'b0;
        first_cycle = 1'b1;
        prev_hold   = 1'b0;
        prev_pc     = '0;
        n_exp       = 0;
        stores_seen = 0;
        holds_seen  = 0;
        cycle_count = 0;
        for (int p = 0; p < N_PROGS; p++) begin
            @(posedge i_clk);
            #1;
            i_rst = 1'b1;
            build_program();
            n_exp       = exp_addr.size();
            stores_seen = 0;
            holds_seen  = 0;
            first_cycle = 1'b1;
            prev_hold   = 1'b0;
            repeat (RST_CYCLES) @(posedge i_clk);
            #1;
            i_rst      = 1'b0;
            run_active = 1'b1;
            wait (stores_seen == n_exp);
            // Trailing no-ops must not store
            repeat (DRAIN) @(posedge i_clk);
            run_active = 1'b0;
            assert (holds_seen == exp_stalls) else begin
                $display("[FAIL] o_pc hold count got %h expected %h", holds_seen, exp_stalls);
                report_failure();
            end
            $display("Program %0d: %0d stores, %0d load-use stalls", p, n_exp, holds_seen);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/core_isa_pkg.sv
logic/core_pipe_pkg.sv
logic/core_fetch.sv
logic/core_regfile.sv
logic/core_decode.sv
logic/core_execute.sv
logic/core_memory.sv
logic/core_top.sv
tests/core_top_tb.sv
